//--- logic/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
  input  logic                  clk,
  input  logic                  reset_i,
  input  isa_pkg::instr_u       instr_i,
  input  logic                  instr_valid_i,
  output logic                  take_o,
  output isa_pkg::reg_idx_t     rs1_addr_o,
  output isa_pkg::reg_idx_t     rs2_addr_o,
  input  isa_pkg::word_t        rs1_data_i,
  input  isa_pkg::word_t        rs2_data_i,
  output mem_bus_pkg::mem_req_t cmd_o,
  output logic                  cmd_valid_o,
  input  logic                  done_i,
  input  isa_pkg::word_t        load_data_i,
  output isa_pkg::retire_t      retire_o,
  output logic                  retire_valid_o
);

  typedef enum logic {
    IDLE,
    WAIT_MEM
  } state_e;

  state_e           state_q;
  logic             load_q;
  isa_pkg::retire_t retire_q;
  logic             retire_valid_q;
  isa_pkg::opcode_e opcode;
  logic             is_op;
  logic             is_op_imm;
  logic             is_lui;
  logic             is_load;
  logic             is_store;
  logic             is_mem;
  logic             sub_sra;
  isa_pkg::alu_op_e alu_op;
  isa_pkg::word_t   imm;
  isa_pkg::word_t   op_b;
  isa_pkg::word_t   alu_res;
  isa_pkg::word_t   result;

  // ==============================
  // decode
  // ==============================

  assign opcode    = instr_i.r.opcode;
  assign is_op     = opcode == isa_pkg::OP;
  assign is_op_imm = opcode == isa_pkg::OP_IMM;
  assign is_lui    = opcode == isa_pkg::LUI;
  assign is_load   = opcode == isa_pkg::LOAD;
  assign is_store  = opcode == isa_pkg::STORE;
  assign is_mem    = is_load || is_store;

  assign rs1_addr_o = instr_i.r.rs1;
  assign rs2_addr_o = instr_i.r.rs2;

  // sign-extended immediate, field layout picked by opcode
  always_comb begin
    case (opcode)
      isa_pkg::STORE: imm = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      isa_pkg::LUI:   imm = {instr_i.u.imm, 12'b0};
      default:        imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    endcase
  end

  // funct7 bit 5 only selects sub for OP, sra for both
  assign sub_sra = instr_i.r.funct7[5] && (is_op || instr_i.r.funct3 == 3'b101);

  always_comb begin
    alu_op = isa_pkg::ADD;
    if (is_op || is_op_imm) begin
      case (instr_i.r.funct3)
        3'b000:  alu_op = sub_sra ? isa_pkg::SUB : isa_pkg::ADD;
        3'b001:  alu_op = isa_pkg::SLL;
        3'b010:  alu_op = isa_pkg::SLT;
        3'b011:  alu_op = isa_pkg::SLTU;
        3'b100:  alu_op = isa_pkg::XOR;
        3'b101:  alu_op = sub_sra ? isa_pkg::SRA : isa_pkg::SRL;
        3'b110:  alu_op = isa_pkg::OR;
        default: alu_op = isa_pkg::AND;
      endcase
    end
  end

  // ==============================
  // alu
  // ==============================

  assign op_b = is_op ? rs2_data_i : imm;

  always_comb begin
    case (alu_op)
      isa_pkg::ADD:  alu_res = rs1_data_i + op_b;
      isa_pkg::SUB:  alu_res = rs1_data_i - op_b;
      isa_pkg::SLL:  alu_res = rs1_data_i << op_b[4:0];
      isa_pkg::SLT:  alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
      isa_pkg::SLTU: alu_res = {31'b0, rs1_data_i < op_b};
      isa_pkg::XOR:  alu_res = rs1_data_i ^ op_b;
      isa_pkg::SRL:  alu_res = rs1_data_i >> op_b[4:0];
      isa_pkg::SRA:  alu_res = $signed(rs1_data_i) >>> op_b[4:0];
      isa_pkg::OR:   alu_res = rs1_data_i | op_b;
      default:       alu_res = rs1_data_i & op_b;
    endcase
  end

  assign result = is_lui ? imm : alu_res;

  // ==============================
  // sequencing
  // ==============================

  // no take while a writeback is still landing in the register file
  assign take_o      = state_q == IDLE && instr_valid_i && !retire_valid_q;
  assign cmd_o       = '{addr: alu_res, wdata: rs2_data_i, we: is_store};
  assign cmd_valid_o = take_o && is_mem;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q        <= IDLE;
      load_q         <= 1'b0;
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (take_o && is_mem) begin
            state_q <= WAIT_MEM;
            load_q  <= is_load;
          end else if (take_o) begin
            retire_valid_q <= 1'b1;
          end
        end
        default: begin
          if (done_i) begin
            state_q        <= IDLE;
            retire_valid_q <= load_q;
          end
        end
      endcase
    end
  end

  // rd captured at take, load value filled in on done
  always_ff @(posedge clk) begin
    if (take_o) begin
      retire_q <= '{rd: instr_i.r.rd, value: result};
    end else if (state_q == WAIT_MEM && done_i) begin
      retire_q.value <= load_data_i;
    end
  end

  assign retire_o       = retire_q;
  assign retire_valid_o = retire_valid_q;

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  reset_i,
  output mem_bus_pkg::mem_req_t req_o,
  output logic                  req_valid_o,
  input  logic                  grant_i,
  input  logic                  rsp_valid_i,
  input  isa_pkg::word_t        rdata_i,
  output isa_pkg::instr_u       instr_o,
  output logic                  instr_valid_o,
  input  logic                  take_i
);

  isa_pkg::word_t  pc_q;
  isa_pkg::instr_u buf_q;
  logic            full_q;
  logic            pending_q;
  logic            req_q;
  logic            full_d;
  logic            pending_d;

  // buffer and outstanding read as seen after this edge
  always_comb begin
    full_d    = full_q;
    pending_d = pending_q;
    if (req_q && grant_i) begin
      pending_d = 1'b1;
    end
    if (rsp_valid_i) begin
      pending_d = 1'b0;
      full_d    = 1'b1;
    end
    if (take_i) begin
      full_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q      <= RESET_PC;
      buf_q     <= isa_pkg::NOP_INSTR;
      full_q    <= 1'b0;
      pending_q <= 1'b0;
      req_q     <= 1'b0;
    end else begin
      full_q    <= full_d;
      pending_q <= pending_d;
      // request again as soon as the buffer drains, held until granted
      req_q     <= !full_d && !pending_d;
      if (rsp_valid_i) begin
        buf_q <= rdata_i;
      end
      if (take_i) begin
        pc_q <= pc_q + mem_bus_pkg::WORD_BYTES;
      end
    end
  end

  assign req_o         = '{addr: pc_q, wdata: '0, we: 1'b0};
  assign req_valid_o   = req_q;
  assign instr_o       = buf_q;
  assign instr_valid_o = full_q;

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_op_e;

  // ==============================
  // instruction formats
  // ==============================

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  // one fetched word, read through the view its opcode selects
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } instr_u;

  // writeback record
  typedef struct packed {
    reg_idx_t rd;
    word_t    value;
  } retire_t;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

//--- logic/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit (
  input  logic                  clk,
  input  logic                  reset_i,
  input  mem_bus_pkg::mem_req_t cmd_i,
  input  logic                  cmd_valid_i,
  output mem_bus_pkg::mem_req_t req_o,
  output logic                  req_valid_o,
  input  logic                  grant_i,
  input  logic                  rsp_valid_i,
  input  isa_pkg::word_t        rdata_i,
  output logic                  done_o,
  output isa_pkg::word_t        load_data_o
);

  mem_bus_pkg::mem_req_t req_q;
  logic                  req_valid_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
    end else if (cmd_valid_i) begin
      req_valid_q <= 1'b1;
    end else if (grant_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      req_q <= cmd_i;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  // store finishes on its grant, load on its response
  assign done_o      = (req_valid_q && grant_i && req_q.we) || rsp_valid_i;
  assign load_data_o = rdata_i;

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                  clk,
  input  logic                  reset_i,
  input  mem_bus_pkg::mem_req_t fetch_req_i,
  input  logic                  fetch_req_valid_i,
  input  mem_bus_pkg::mem_req_t lsu_req_i,
  input  logic                  lsu_req_valid_i,
  output logic                  fetch_grant_o,
  output logic                  lsu_grant_o,
  output mem_bus_pkg::mem_req_t mem_req_o,
  output logic                  mem_req_valid_o,
  output logic                  fetch_rsp_valid_o,
  output logic                  lsu_rsp_valid_o
);

  // owner of the read issued last cycle
  logic fetch_rd_q;
  logic lsu_rd_q;

  // data access first, fetch takes the port otherwise
  assign lsu_grant_o     = lsu_req_valid_i;
  assign fetch_grant_o   = fetch_req_valid_i && !lsu_req_valid_i;
  assign mem_req_o       = lsu_req_valid_i ? lsu_req_i : fetch_req_i;
  assign mem_req_valid_o = lsu_req_valid_i || fetch_req_valid_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      fetch_rd_q <= 1'b0;
      lsu_rd_q   <= 1'b0;
    end else begin
      fetch_rd_q <= fetch_grant_o && !fetch_req_i.we;
      // stores get no response
      lsu_rd_q   <= lsu_grant_o && !lsu_req_i.we;
    end
  end

  assign fetch_rsp_valid_o = fetch_rd_q;
  assign lsu_rsp_valid_o   = lsu_rd_q;

endmodule

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

  // ==============================
  // shared memory port
  // ==============================

  // one request, read when we is low
  typedef struct packed {
    isa_pkg::word_t addr;
    isa_pkg::word_t wdata;
    logic           we;
  } mem_req_t;

  // read data, one cycle after the request
  typedef struct packed {
    isa_pkg::word_t rdata;
  } mem_rsp_t;

  // bytes per bus word, also the pc step
  localparam isa_pkg::word_t WORD_BYTES = 32'd4;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic              clk,
  input  logic              reset_i,
  input  isa_pkg::reg_idx_t rs1_addr_i,
  input  isa_pkg::reg_idx_t rs2_addr_i,
  output isa_pkg::word_t    rs1_data_o,
  output isa_pkg::word_t    rs2_data_o,
  input  isa_pkg::retire_t  wr_i,
  input  logic              wr_valid_i
);

  isa_pkg::word_t regs_q [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int n = 0; n < 32; n++) begin
        regs_q[n] <= '0;
      end
    end else if (wr_valid_i && wr_i.rd != '0) begin
      // x0 never written, so it reads back zero
      regs_q[wr_i.rd] <= wr_i.value;
    end
  end

  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

//--- logic/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  reset_i,
  output mem_bus_pkg::mem_req_t mem_req_o,
  output logic                  mem_req_valid_o,
  input  mem_bus_pkg::mem_rsp_t mem_rsp_i,
  output isa_pkg::retire_t      retire_o,
  output logic                  retire_valid_o
);

  mem_bus_pkg::mem_req_t fetch_req;
  logic                  fetch_req_valid;
  logic                  fetch_grant;
  logic                  fetch_rsp_valid;
  mem_bus_pkg::mem_req_t lsu_req;
  logic                  lsu_req_valid;
  logic                  lsu_grant;
  logic                  lsu_rsp_valid;
  isa_pkg::instr_u       instr;
  logic                  instr_valid;
  logic                  take;
  isa_pkg::reg_idx_t     rs1_addr;
  isa_pkg::reg_idx_t     rs2_addr;
  isa_pkg::word_t        rs1_data;
  isa_pkg::word_t        rs2_data;
  mem_bus_pkg::mem_req_t cmd;
  logic                  cmd_valid;
  logic                  done;
  isa_pkg::word_t        load_data;

  // ==============================
  // memory side
  // ==============================

  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_o        (fetch_req),
    .req_valid_o  (fetch_req_valid),
    .grant_i      (fetch_grant),
    .rsp_valid_i  (fetch_rsp_valid),
    .rdata_i      (mem_rsp_i.rdata),
    .instr_o      (instr),
    .instr_valid_o(instr_valid),
    .take_i       (take)
  );

  load_store_unit u_lsu (
    .clk        (clk),
    .reset_i    (reset_i),
    .cmd_i      (cmd),
    .cmd_valid_i(cmd_valid),
    .req_o      (lsu_req),
    .req_valid_o(lsu_req_valid),
    .grant_i    (lsu_grant),
    .rsp_valid_i(lsu_rsp_valid),
    .rdata_i    (mem_rsp_i.rdata),
    .done_o     (done),
    .load_data_o(load_data)
  );

  mem_arbiter u_arb (
    .clk              (clk),
    .reset_i          (reset_i),
    .fetch_req_i      (fetch_req),
    .fetch_req_valid_i(fetch_req_valid),
    .lsu_req_i        (lsu_req),
    .lsu_req_valid_i  (lsu_req_valid),
    .fetch_grant_o    (fetch_grant),
    .lsu_grant_o      (lsu_grant),
    .mem_req_o        (mem_req_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .fetch_rsp_valid_o(fetch_rsp_valid),
    .lsu_rsp_valid_o  (lsu_rsp_valid)
  );

  // ==============================
  // execution side
  // ==============================

  reg_file u_regs (
    .clk       (clk),
    .reset_i   (reset_i),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_i      (retire_o),
    .wr_valid_i(retire_valid_o)
  );

  execute_unit u_exec (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .take_o        (take),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .cmd_o         (cmd),
    .cmd_valid_o   (cmd_valid),
    .done_i        (done),
    .load_data_i   (load_data),
    .retire_o      (retire_o),
    .retire_valid_o(retire_valid_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module rv_core_tb -f rv_core.f

./obj_dir/Vrv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- rv_core.f
+incdir+tests
logic/isa_pkg.sv
logic/mem_bus_pkg.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/rv_core.sv
tests/rv_core_tb.sv

//--- tests/rv_iss_model.svh
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// ==============================
// instruction-set reference model
// ==============================

isa_pkg::word_t        iss_x [32];
isa_pkg::word_t        iss_mem [isa_pkg::word_t];
isa_pkg::retire_t      exp_retire_q [$];
mem_bus_pkg::mem_req_t exp_access_q [$];

// runs one word and queues what the core has to show for it
task automatic iss_step(input isa_pkg::word_t w);
  isa_pkg::reg_idx_t rd;
  isa_pkg::word_t    a;
  isa_pkg::word_t    b;
  isa_pkg::word_t    imm_i;
  isa_pkg::word_t    addr;
  isa_pkg::word_t    res;
  logic              is_op;
  logic              wb;
  rd    = w[11:7];
  is_op = w[6:0] == isa_pkg::OP;
  a     = iss_x[w[19:15]];
  imm_i = {{20{w[31]}}, w[31:20]};
  b     = is_op ? iss_x[w[24:20]] : imm_i;
  wb    = 1'b1;
  case (w[6:0])
    isa_pkg::LUI: res = {w[31:12], 12'b0};
    isa_pkg::LOAD: begin
      addr = a + imm_i;
      exp_access_q.push_back('{addr: addr, wdata: '0, we: 1'b0});
      res = iss_mem[addr];
    end
    isa_pkg::STORE: begin
      addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      iss_mem[addr] = iss_x[w[24:20]];
      exp_access_q.push_back('{addr: addr, wdata: iss_x[w[24:20]], we: 1'b1});
      res = '0;
      wb  = 1'b0;
    end
    default: begin
      case (w[14:12])
        // only the register form has sub
        3'b000:  res = (is_op && w[30]) ? a - b : a + b;
        3'b001:  res = a << b[4:0];
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  res = (a < b) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ b;
        3'b101: begin
          if (w[30]) begin
            res = $signed(a) >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
        end
        3'b110:  res = a | b;
        default: res = a & b;
      endcase
    end
  endcase
  if (wb) begin
    if (rd != '0) begin
      iss_x[rd] = res;
    end
    exp_retire_q.push_back('{rd: rd, value: res});
  end
endtask

task automatic check_retire(input string name, input isa_pkg::retire_t exp,
                            input isa_pkg::retire_t act);
  if (act !== exp) begin
    stop_with_error($sformatf("Fail %s: expected x%0d = %h, actual x%0d = %h",
                              name, exp.rd, exp.value, act.rd, act.value));
  end
endtask

task automatic check_store(input string name, input mem_bus_pkg::mem_req_t exp,
                           input mem_bus_pkg::mem_req_t act);
  if (act !== exp) begin
    stop_with_error($sformatf("Fail %s: expected [%h] <= %h we %b, actual [%h] <= %h we %b",
                              name, exp.addr, exp.wdata, exp.we,
                              act.addr, act.wdata, act.we));
  end
endtask

`endif

//--- tests/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

  localparam isa_pkg::word_t RESET_PC     = 32'h0000_0040;
  localparam int             N_INSTR      = 200;
  localparam int             CLK_PERIOD   = 20;
  localparam int             RESET_CYCLES = 16;
  localparam int             DATA_WORDS   = 64;
  localparam int             TIMEOUT_NS   = (RESET_CYCLES + N_INSTR * 8) * CLK_PERIOD;
  // data offset reached from x0 through sign extension
  localparam logic [11:0]    DATA_IMM     = 12'h800;
  localparam isa_pkg::word_t DATA_BASE    = {{20{DATA_IMM[11]}}, DATA_IMM};

  logic                  clk = 1'b0;
  logic                  reset_i;
  mem_bus_pkg::mem_req_t mem_req;
  logic                  mem_req_valid;
  mem_bus_pkg::mem_rsp_t mem_rsp;
  isa_pkg::retire_t      retire;
  logic                  retire_valid;

  integer                seed = 32'h1eb0_a7dc;
  isa_pkg::word_t        mem_image [isa_pkg::word_t];
  isa_pkg::word_t        next_fetch = RESET_PC;
  int                    done_count = 0;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  `include "rv_iss_model.svh"

  rv_core #(
    .RESET_PC(RESET_PC)
  ) u_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .mem_req_o      (mem_req),
    .mem_req_valid_o(mem_req_valid),
    .mem_rsp_i      (mem_rsp),
    .retire_o       (retire),
    .retire_valid_o (retire_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // program generation
  // ==============================

  function automatic isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OP};
  endfunction

  function automatic isa_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  // unmapped words still differ at every address
  function automatic isa_pkg::word_t read_word(input isa_pkg::word_t addr);
    if (mem_image.exists(addr)) begin
      return mem_image[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h6b3c_d1e5;
  endfunction

  task automatic build_program();
    isa_pkg::word_t w;
    isa_pkg::word_t v;
    logic [11:0]    off;
    logic [11:0]    imm;
    logic [2:0]     f3;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic [4:0]     rs2;
    logic [4:0]     last_load_rd;
    logic           alt;
    int             kind;
    last_load_rd = '0;
    for (int r = 0; r < 32; r++) begin
      iss_x[r] = '0;
    end
    for (int k = 0; k < DATA_WORDS; k++) begin
      v = $random(seed);
      mem_image[DATA_BASE + mem_bus_pkg::WORD_BYTES * k] = v;
      iss_mem[DATA_BASE + mem_bus_pkg::WORD_BYTES * k]   = v;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      kind = $unsigned($random(seed)) % 10;
      rd   = 5'($unsigned($random(seed)) % 31 + 1);
      rs1  = 5'($random(seed));
      rs2  = 5'($random(seed));
      f3   = 3'($random(seed));
      alt  = 1'($random(seed));
      imm  = 12'($random(seed));
      off  = DATA_IMM + 12'(4 * ($unsigned($random(seed)) % DATA_WORDS));
      // next alu op reads the loaded register
      if (last_load_rd != '0) begin
        rs1 = last_load_rd;
      end
      last_load_rd = '0;
      if (kind < 4) begin
        w = enc_r((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, alt, 5'b0} : 7'b0, rs2, rs1, f3, rd);
      end else if (kind < 7) begin
        if (f3 == 3'b001) begin
          imm = {7'b0, rs2};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, alt, 5'b0, rs2};
        end
        w = enc_i(imm, rs1, f3, rd, isa_pkg::OP_IMM);
      end else if (kind == 7) begin
        w = {20'($random(seed)), rd, isa_pkg::LUI};
      end else if (kind == 8) begin
        w = enc_i(off, 5'd0, 3'b010, rd, isa_pkg::LOAD);
        last_load_rd = rd;
      end else begin
        w = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], isa_pkg::STORE};
      end
      mem_image[RESET_PC + mem_bus_pkg::WORD_BYTES * i] = w;
      iss_step(w);
    end
  endtask

  initial begin
    reset_i <= 1'b1;
    mem_rsp <= '0;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
  end

  // memory model answers each read one cycle later
  always @(posedge clk) begin
    if (mem_req_valid === 1'b1) begin
      if (mem_req.we) begin
        mem_image[mem_req.addr] = mem_req.wdata;
      end else begin
        mem_rsp <= '{rdata: read_word(mem_req.addr)};
      end
    end
  end

  // ==============================
  // checks
  // ==============================

  always @(posedge clk) begin : monitor
    mem_bus_pkg::mem_req_t exp_acc;
    if (reset_i === 1'b1) begin
      if (mem_req_valid === 1'b1 || retire_valid === 1'b1) begin
        stop_with_error("bus request or retire seen while reset is high");
      end
    end else begin
      if (retire_valid) begin
        if (exp_retire_q.size() == 0) begin
          stop_with_error("retire seen with no writeback left in the program");
        end else begin
          check_retire($sformatf("retire %0d", done_count), exp_retire_q.pop_front(), retire);
          done_count++;
        end
      end
      if (mem_req_valid) begin
        if (!mem_req.we && mem_req.addr == next_fetch) begin
          next_fetch = next_fetch + mem_bus_pkg::WORD_BYTES;
        end else if (exp_access_q.size() == 0) begin
          stop_with_error($sformatf("unexpected bus request at %h, next fetch is %h",
                                    mem_req.addr, next_fetch));
        end else begin
          exp_acc = exp_access_q.pop_front();
          if (exp_acc.we) begin
            check_store($sformatf("store %0d", done_count), exp_acc, mem_req);
            done_count++;
          end else if (mem_req.we || mem_req.addr != exp_acc.addr) begin
            stop_with_error($sformatf("bus request at %h we %b is neither fetch %h nor load %h",
                                      mem_req.addr, mem_req.we, next_fetch, exp_acc.addr));
          end
        end
      end
      if (done_count == N_INSTR) begin
        if (exp_retire_q.size() == 0 && exp_access_q.size() == 0) begin
          $display("Test passed");
          $finish;
        end else begin
          stop_with_error("all instructions counted but expected results are left over");
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_error($sformatf("timeout after %0d ns, %0d of %0d instructions done",
                              TIMEOUT_NS, done_count, N_INSTR));
  end

endmodule
